// File: source/scan_pkg.sv
package scan_pkg;

    //////////////////////////////////////////////////
    // serial line timing
    //////////////////////////////////////////////////

    localparam int CLKS_PER_BIT = 16;    // oversampling ratio, clocks per bit

    //////////////////////////////////////////////////
    // byte buffer between receiver and scanner
    //////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 8;       // entries
    localparam int FIFO_AW    = 3;       // pointer width, log2 of depth

    //////////////////////////////////////////////////
    // scanner token rules
    //////////////////////////////////////////////////

    localparam int WORD_BYTES = 4;       // max bytes packed into one token

    // control characters seen by the word scan
    localparam logic [7:0] CH_SPACE = 8'h20;   // skipped before first kept byte
    localparam logic [7:0] CH_CR    = 8'h0d;   // always dropped
    localparam logic [7:0] CH_LF    = 8'h0a;   // ends token early

endpackage

// File: source/uart_rx.sv
module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_stb,
    output logic       frame_err
);
    import scan_pkg::*;

    localparam int HALF_BIT = CLKS_PER_BIT / 2;
    localparam int CW       = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP
    } rx_state_t;

    rx_state_t   state;
    logic        rxd_meta;   // first sync stage
    logic        rxd_sync;   // second sync stage
    logic        rxd_prev;   // for falling edge detect
    logic [CW-1:0] clk_cnt;  // clocks within current bit
    logic [2:0]  bit_idx;    // data bit number
    logic [7:0]  shreg;      // lsb arrives first

    // two flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    //////////////////////////////////////////////////
    // frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= S_IDLE;
            clk_cnt   <= '0;
            bit_idx   <= '0;
            rx_stb    <= 1'b0;
            frame_err <= 1'b0;
        end
        else
        begin
            rx_stb    <= 1'b0;   // single cycle pulses
            frame_err <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    clk_cnt <= '0;
                    if (rxd_prev && !rxd_sync)   // start edge
                        state <= S_START;
                end
                S_START:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == HALF_BIT - 1)   // middle of start bit
                    begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch, not a real start bit
                        state   <= rxd_sync ? S_IDLE : S_DATA;
                    end
                end
                S_DATA:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CLKS_PER_BIT - 1)
                    begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= S_STOP;
                    end
                end
                S_STOP:
                begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == CLKS_PER_BIT - 1)   // mid stop bit
                    begin
                        rx_stb    <= rxd_sync;
                        frame_err <= !rxd_sync;   // low stop bit, byte dropped
                        state     <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // data path, sample at mid bit
    always_ff @(posedge clk)
    begin
        if (state == S_DATA && clk_cnt == CLKS_PER_BIT - 1)
            shreg <= {rxd_sync, shreg[7:1]};
        if (state == S_STOP && clk_cnt == CLKS_PER_BIT - 1)
            rx_byte <= shreg;
    end

endmodule

// File: source/rx_byte_buffer.sv
module rx_byte_buffer (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_byte,
    input  logic       rx_stb,
    input  logic       rdy_rx,
    output logic [7:0] d_rx,
    output logic       vld_rx,
    output logic       overrun
);
    import scan_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;    // occupancy, 0..FIFO_DEPTH
    logic               full;
    logic               push;
    logic               pop;

    assign full = (count == FIFO_DEPTH);
    assign push = rx_stb && !full;   // byte lost when full
    assign pop  = vld_rx && rdy_rx;  // scanner handshake

    assign vld_rx = (count != 0);
    assign d_rx   = mem[rd_ptr];     // head of queue

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            // pointers wrap naturally, depth is a power of two
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            overrun <= rx_stb && full;
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= rx_byte;
    end

endmodule

// File: source/rx_scan.sv
module rx_scan (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  d_rx,
    input  logic        vld_rx,
    input  logic        req,
    input  logic        req_word,
    output logic        rdy_rx,
    output logic        ack,
    output logic        flag,
    output logic [31:0] data
);
    import scan_pkg::*;

    localparam int CNT_W = $clog2(WORD_BYTES) + 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_BYTE,
        S_WORD,
        S_DONE
    } scan_state_t;

    scan_state_t      state;
    scan_state_t      next_state;
    logic [CNT_W-1:0] cnt;        // kept bytes in token
    logic             hs;         // byte consumed this cycle
    logic             is_lf;
    logic             is_cr;
    logic             lead_sp;    // space before anything kept
    logic             last_kept;  // this byte fills the token

    assign rdy_rx = (state == S_BYTE) || (state == S_WORD);
    assign ack    = (state == S_DONE);   // one cycle, then idle
    assign hs     = vld_rx && rdy_rx;

    assign is_lf     = (d_rx == CH_LF);
    assign is_cr     = (d_rx == CH_CR);
    assign lead_sp   = (d_rx == CH_SPACE) && (cnt == 0);
    assign last_kept = (cnt == WORD_BYTES - 1);

    //////////////////////////////////////////////////
    // state transitions
    //////////////////////////////////////////////////

    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (req)
                    next_state = req_word ? S_WORD : S_BYTE;
            end
            S_BYTE:
            begin
                if (hs)
                    next_state = S_DONE;
            end
            S_WORD:
            begin
                // lf ends early, otherwise stop at a full token
                if (hs && (is_lf || (!is_cr && !lead_sp && last_kept)))
                    next_state = S_DONE;
            end
            S_DONE:   next_state = S_IDLE;
            default:  next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    //////////////////////////////////////////////////
    // token assembly
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            data <= '0;
            flag <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    cnt <= '0;
                    if (req)   // fresh result for new request
                    begin
                        data <= '0;
                        flag <= 1'b0;
                    end
                end
                S_BYTE:
                begin
                    if (hs)
                    begin
                        data <= {24'h000000, d_rx};   // raw, no filtering
                        flag <= 1'b0;
                    end
                end
                S_WORD:
                begin
                    if (hs)
                    begin
                        if (is_lf)
                            flag <= (cnt == 0);   // empty token
                        else if (!is_cr && !lead_sp)
                        begin
                            data <= {data[23:0], d_rx};   // msb first
                            cnt  <= cnt + 1'b1;
                            flag <= 1'b0;
                        end
                    end
                end
                default: ;   // done holds result
            endcase
        end
    end

endmodule

// File: source/scan_rx_top.sv
module scan_rx_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        rxd,
    input  logic        req,
    input  logic        req_word,
    output logic        ack,
    output logic        flag,
    output logic [31:0] data,
    output logic        frame_err,
    output logic        overrun
);

    logic [7:0] rx_byte;   // receiver to buffer
    logic       rx_stb;
    logic [7:0] d_rx;      // buffer to scanner
    logic       vld_rx;
    logic       rdy_rx;

    //////////////////////////////////////////////////
    // receiver -> buffer -> scanner
    //////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .rx_byte   (rx_byte),
        .rx_stb    (rx_stb),
        .frame_err (frame_err)
    );

    rx_byte_buffer u_buffer (
        .clk     (clk),
        .rst     (rst),
        .rx_byte (rx_byte),
        .rx_stb  (rx_stb),
        .rdy_rx  (rdy_rx),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .overrun (overrun)
    );

    rx_scan u_scan (
        .clk      (clk),
        .rst      (rst),
        .d_rx     (d_rx),
        .vld_rx   (vld_rx),
        .req      (req),
        .req_word (req_word),
        .rdy_rx   (rdy_rx),
        .ack      (ack),
        .flag     (flag),
        .data     (data)
    );

endmodule

// File: bench/scan_rx_assertions.sv
module scan_rx_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         ack,      // scanner result strobe
    input logic                         rdy_rx,   // scanner taking bytes
    input logic                         vld_rx,   // buffer not empty
    input logic [scan_pkg::FIFO_AW:0]   count,    // buffer occupancy
    input logic [scan_pkg::FIFO_AW-1:0] wr_ptr,   // next slot to fill
    input logic [scan_pkg::FIFO_AW-1:0] rd_ptr    // head of queue
);
    import scan_pkg::*;

    //////////////////////////////////////////////////
    // scanner handshake
    //////////////////////////////////////////////////

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
        else $error("ack high for two cycles in a row");

    // done state never takes a byte
    a_no_rdy_on_ack: assert property (@(posedge clk) disable iff (rst) ack |-> !rdy_rx)
        else $error("rdy_rx high in the ack cycle");

    //////////////////////////////////////////////////
    // byte buffer
    //////////////////////////////////////////////////

    a_occupancy: assert property (@(posedge clk) disable iff (rst) count <= FIFO_DEPTH)
        else $error("buffer occupancy above depth");

    // pointers meet when empty or full, only the count tells them apart
    a_empty_not_valid: assert property (@(posedge clk) disable iff (rst)
        (wr_ptr == rd_ptr && count != FIFO_DEPTH) |-> !vld_rx)
        else $error("vld_rx high with an empty buffer");

endmodule

// reaches into both the scanner and the buffer
bind scan_rx_top scan_rx_assertions u_assertions (
    .clk    (clk),
    .rst    (rst),
    .ack    (u_scan.ack),
    .rdy_rx (u_scan.rdy_rx),
    .vld_rx (u_buffer.vld_rx),
    .count  (u_buffer.count),
    .wr_ptr (u_buffer.wr_ptr),
    .rd_ptr (u_buffer.rd_ptr)
);

// File: bench/scan_rx_tb.sv
module scan_rx_tb;
    import scan_pkg::*;

    localparam int MAX_TESTS = 64;
    localparam int ACK_WAIT  = 4 * 12 * CLKS_PER_BIT;   // cycles after last frame

    logic        clk;
    logic        rst;
    logic        rxd;
    logic        req;
    logic        req_word;
    logic        ack;
    logic        flag;
    logic [31:0] data;
    logic        frame_err;
    logic        overrun;

    // test table from the data file
    int          kind_a     [MAX_TESTS];   // 0 none, 1 byte, 2 word
    int          nb_a       [MAX_TESTS];
    logic [7:0]  byte_a     [MAX_TESTS][8];
    logic [7:0]  mask_a     [MAX_TESTS];   // low stop bit per byte
    logic [31:0] exp_data_a [MAX_TESTS];
    logic        exp_flag_a [MAX_TESTS];
    int          exp_ferr_a [MAX_TESTS];
    int          exp_ovr_a  [MAX_TESTS];
    int          num_tests   = 0;
    int          total_bytes = 0;
    bit          loaded      = 0;

    int          ack_total  = 0;   // pulse counters, sampled at negedge
    int          ferr_total = 0;
    int          ovr_total  = 0;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;
    int          cur_test;
    bit          test_ok;
    logic [31:0] rng_state;

    scan_rx_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .rxd       (rxd),
        .req       (req),
        .req_word  (req_word),
        .ack       (ack),
        .flag      (flag),
        .data      (data),
        .frame_err (frame_err),
        .overrun   (overrun)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // count strobes away from the active edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (ack)
                ack_total++;
            if (frame_err)
                ferr_total++;
            if (overrun)
                ovr_total++;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // one line level for whole bit periods
    task automatic hold_bit(input logic v, input int nbits);
        @(posedge clk);
        rxd <= v;
        repeat (nbits * CLKS_PER_BIT - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] b, input logic bad_stop);
        int gap;
        rng_state = xorshift32(rng_state);
        gap = (rng_state % 4) + 1;   // idle bits after the frame
        hold_bit(1'b0, 1);           // start
        for (int i = 0; i < 8; i++)
            hold_bit(b[i], 1);       // lsb first
        hold_bit(!bad_stop, 1);
        hold_bit(1'b1, gap);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERROR test %0d: %s expected 0x%08h got 0x%08h", cur_test, name, exp, act);
            test_ok = 0;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR test %0d: %s expected 0x%0h got 0x%0h", cur_test, name, exp, act);
            test_ok = 0;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
        begin
            $display("ERROR test %0d: %s expected 0x%0h got 0x%0h", cur_test, name, exp, act);
            test_ok = 0;
        end
    endtask

    task automatic load_tests();
        int fd;
        int n;
        logic [8*200-1:0] line;
        fd = $fopen("bench/scan_rx_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the tests file bench/scan_rx_tests.txt");
        end
        else
        begin
            while (!$feof(fd) && num_tests < MAX_TESTS)
            begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %h %h %h %d %d",
                    kind_a[num_tests], nb_a[num_tests],
                    byte_a[num_tests][0], byte_a[num_tests][1],
                    byte_a[num_tests][2], byte_a[num_tests][3],
                    byte_a[num_tests][4], byte_a[num_tests][5],
                    byte_a[num_tests][6], byte_a[num_tests][7],
                    mask_a[num_tests], exp_data_a[num_tests], exp_flag_a[num_tests],
                    exp_ferr_a[num_tests], exp_ovr_a[num_tests]);
                if (n == 15)   // comments and blank lines fall through
                begin
                    total_bytes += nb_a[num_tests];
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////
    // one test: request, frames, result
    //////////////////////////////////////////////////

    task automatic run_test(input int t);
        int ack_start;
        int ferr_start;
        int ovr_start;
        int waited;
        cur_test = t;
        test_ok  = 1;
        @(posedge clk);
        ack_start  = ack_total;
        ferr_start = ferr_total;
        ovr_start  = ovr_total;
        if (kind_a[t] != 0)
        begin
            req      <= 1'b1;
            req_word <= (kind_a[t] == 2);
            @(posedge clk);
            req      <= 1'b0;
            req_word <= 1'b0;
        end
        for (int i = 0; i < nb_a[t]; i++)
            send_frame(byte_a[t][i], mask_a[t][i]);
        if (kind_a[t] != 0)
        begin
            waited = 0;
            while (ack_total == ack_start && waited < ACK_WAIT)
            begin
                @(negedge clk);
                waited++;
            end
            if (ack_total == ack_start)
            begin
                $display("test %0d: the scanner never answered the request", t);
                test_ok = 0;
            end
            else
            begin
                check_word("data", exp_data_a[t], data);   // held until next req
                check_bit("flag", exp_flag_a[t], flag);
            end
        end
        repeat (2) @(posedge clk);
        check_count("frame_err count", exp_ferr_a[t], ferr_total - ferr_start);
        check_count("overrun count", exp_ovr_a[t], ovr_total - ovr_start);
        if (test_ok)
        begin
            pass_cnt++;
            $display("test %0d ok", t);
        end
        else
        begin
            fail_cnt++;
            $display("test %0d failed", t);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial
    begin
        rst       = 1'b1;
        rxd       = 1'b1;   // idle line
        req       = 1'b0;
        req_word  = 1'b0;
        rng_state = 32'd60778;
        load_tests();
        if (num_tests == 0)
            fail_cnt++;      // nothing loaded counts as a failure
        loaded = 1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        for (int t = 0; t < num_tests; t++)
            run_test(t);
        @(posedge clk);
        $display("%0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        longint limit;
        wait (loaded);
        // frame budget per byte, plus slack for each test's ack wait
        limit = longint'(total_bytes) * 12 * CLKS_PER_BIT * 10
              + longint'(num_tests) * (ACK_WAIT + 50) * 10 + 1000;
        #(limit);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim.f
source/scan_pkg.sv
source/uart_rx.sv
source/rx_byte_buffer.sv
source/rx_scan.sv
source/scan_rx_top.sv
bench/scan_rx_assertions.sv
bench/scan_rx_tb.sv

// File: bench/scan_rx_tests.txt
# kind (0 none, 1 byte, 2 word) nbytes b0..b7 stop_mask exp_data exp_flag exp_ferr exp_ovr
# bytes in hex sent b0 first, mask bit i gives byte i a low stop bit, data and flag unused for kind 0
1 1 41 00 00 00 00 00 00 00 00 00000041 0 0 0
1 1 20 00 00 00 00 00 00 00 00 00000020 0 0 0
1 1 0a 00 00 00 00 00 00 00 00 0000000a 0 0 0
2 4 31 32 33 34 00 00 00 00 00 31323334 0 0 0
2 5 41 42 43 44 45 00 00 00 00 41424344 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000045 0 0 0
2 6 20 20 41 0d 42 0a 00 00 00 00004142 0 0 0
2 2 33 0a 00 00 00 00 00 00 00 00000033 0 0 0
2 2 20 0a 00 00 00 00 00 00 00 00000000 1 0 0
2 2 0d 0a 00 00 00 00 00 00 00 00000000 1 0 0
2 4 31 32 33 0a 00 00 00 00 00 00313233 0 0 0
1 2 55 41 00 00 00 00 00 00 01 00000041 0 1 0
2 5 31 32 33 34 35 00 00 00 02 31333435 0 1 0
0 8 60 61 62 63 64 65 66 67 00 00000000 0 0 0
0 2 68 69 00 00 00 00 00 00 00 00000000 0 0 2
1 0 00 00 00 00 00 00 00 00 00 00000060 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000061 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000062 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000063 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000064 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000065 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000066 0 0 0
1 0 00 00 00 00 00 00 00 00 00 00000067 0 0 0
1 1 5a 00 00 00 00 00 00 00 00 0000005a 0 0 0
